/* compile.f */
hdl/rvc_pkg.sv
hdl/fetch_unit.sv
hdl/instr_queue.sv
hdl/rvc_expander.sv
hdl/fetch_top.sv
verification/tb_fetch_top.sv

/* hdl/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     hold_i,
   input  logic                     redirect_i,
   input  logic [rvc_pkg::xlen-1:0] redirect_pc_i,
   input  logic [rvc_pkg::xlen-1:0] imem_data_i,
   output logic [rvc_pkg::xlen-1:0] imem_addr_o,
   output rvc_pkg::exp_out_t        out_o
);

   rvc_pkg::fetch_req_t fetch_req;
   rvc_pkg::queue_out_t queue_out;
   logic                fetch_stall;

   fetch_unit i_fetch (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .hold_i        (hold_i),
      .redirect_i    (redirect_i),
      .redirect_pc_i (redirect_pc_i),
      .fetch_stall_i (fetch_stall),
      .imem_data_i   (imem_data_i),
      .imem_addr_o   (imem_addr_o),
      .fetch_o       (fetch_req)
   );

   // combinational split, same cycle as the word
   instr_queue i_queue (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .hold_i        (hold_i),
      .redirect_i    (redirect_i),
      .redirect_pc_i (redirect_pc_i),
      .fetch_i       (fetch_req),
      .fetch_stall_o (fetch_stall),
      .queue_o       (queue_out)
   );

   rvc_expander i_expander (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .hold_i  (hold_i),
      .queue_i (queue_out),
      .out_o   (out_o)
   );

endmodule

/* hdl/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     hold_i,
   input  logic                     redirect_i,
   input  logic [rvc_pkg::xlen-1:0] redirect_pc_i,
   input  logic                     fetch_stall_i,
   input  logic [rvc_pkg::xlen-1:0] imem_data_i,
   output logic [rvc_pkg::xlen-1:0] imem_addr_o,
   output rvc_pkg::fetch_req_t      fetch_o
);

   logic [rvc_pkg::xlen-1:0] addr_r;
   logic [rvc_pkg::xlen-1:0] addr_nx;
   logic                     advance;

   // word is consumed only when nothing blocks it
   assign advance = !hold_i && !fetch_stall_i && !redirect_i;

   always_comb begin
      addr_nx = addr_r;
      if (redirect_i) begin
         // queue remembers bit 1, memory only sees words
         addr_nx = {redirect_pc_i[rvc_pkg::xlen-1:2], 2'b00};
      end
      else if (advance) begin
         addr_nx = addr_r + 32'd4;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         addr_r <= rvc_pkg::reset_pc;
      end
      else if (!hold_i) begin
         addr_r <= addr_nx;
      end
   end

   assign imem_addr_o = addr_r;

   // memory answers in the same cycle
   always_comb begin
      fetch_o           = '0;
      fetch_o.data.word = imem_data_i;
      fetch_o.addr      = addr_r;
      fetch_o.valid     = advance;
   end

   a_addr_aligned: assert property (
      @(posedge clk_i) disable iff (!rst_i)
      imem_addr_o[1:0] == 2'b00
   ) else $error("fetch address not word aligned: %h", imem_addr_o);

endmodule

/* hdl/instr_queue.sv */
`timescale 1ns/1ps

module instr_queue (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     hold_i,
   input  logic                     redirect_i,
   input  logic [rvc_pkg::xlen-1:0] redirect_pc_i,
   input  rvc_pkg::fetch_req_t      fetch_i,
   output logic                     fetch_stall_o,
   output rvc_pkg::queue_out_t      queue_o
);

   logic [1:0]               state_r;
   logic [1:0]               state_nx;
   logic [15:0]              parcel_r;
   logic [15:0]              parcel_nx;
   logic [rvc_pkg::xlen-1:0] pc_r;
   logic [rvc_pkg::xlen-1:0] pc_nx;
   logic                     active;
   logic                     skip_lo;
   logic                     lo_full;
   logic                     hi_full;
   logic [rvc_pkg::xlen-1:0] word_addr;

   assign active  = !hold_i && !redirect_i;
   assign lo_full = fetch_i.data.half[0][1:0] == rvc_pkg::op_full;
   assign hi_full = fetch_i.data.half[1][1:0] == rvc_pkg::op_full;

   // jump target on the upper parcel
   assign skip_lo = (state_r == rvc_pkg::st_jump) && pc_r[1];

   // second compressed of a word still buffered
   assign fetch_stall_o = state_r == rvc_pkg::st_comp;

   always_comb begin
      state_nx   = state_r;
      parcel_nx  = parcel_r;
      pc_nx      = pc_r;
      queue_o    = '0;
      queue_o.pc = pc_r;

      if (active) begin
         case (state_r)
            rvc_pkg::st_empty,
            rvc_pkg::st_jump: begin
               if (fetch_i.valid) begin
                  state_nx = rvc_pkg::st_empty;
                  if (skip_lo) begin
                     if (hi_full) begin
                        // lower half of a straddling instruction, nothing out yet
                        parcel_nx = fetch_i.data.half[1];
                        state_nx  = rvc_pkg::st_half;
                     end
                     else begin
                        queue_o.instr      = {16'h0000, fetch_i.data.half[1]};
                        queue_o.compressed = 1'b1;
                        queue_o.valid      = 1'b1;
                        pc_nx              = pc_r + 32'd2;
                     end
                  end
                  else if (lo_full) begin
                     queue_o.instr = fetch_i.data.word;
                     queue_o.valid = 1'b1;
                     pc_nx         = pc_r + 32'd4;
                  end
                  else begin
                     queue_o.instr      = {16'h0000, fetch_i.data.half[0]};
                     queue_o.compressed = 1'b1;
                     queue_o.valid      = 1'b1;
                     pc_nx              = pc_r + 32'd2;
                     parcel_nx          = fetch_i.data.half[1];
                     state_nx           = hi_full ? rvc_pkg::st_half : rvc_pkg::st_comp;
                  end
               end
            end

            rvc_pkg::st_half: begin
               // join buffered lower half with the new first parcel
               if (fetch_i.valid) begin
                  queue_o.instr = {fetch_i.data.half[0], parcel_r};
                  queue_o.valid = 1'b1;
                  pc_nx         = pc_r + 32'd4;
                  parcel_nx     = fetch_i.data.half[1];
                  state_nx      = hi_full ? rvc_pkg::st_half : rvc_pkg::st_comp;
               end
            end

            default: begin
               // st_comp, address is held so no word is taken
               queue_o.instr      = {16'h0000, parcel_r};
               queue_o.compressed = 1'b1;
               queue_o.valid      = 1'b1;
               pc_nx              = pc_r + 32'd2;
               state_nx           = rvc_pkg::st_empty;
            end
         endcase
      end

      if (redirect_i) begin
         state_nx = rvc_pkg::st_jump;
         pc_nx    = redirect_pc_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         state_r <= rvc_pkg::st_empty;
         pc_r    <= rvc_pkg::reset_pc;
      end
      else if (!hold_i) begin
         state_r <= state_nx;
         pc_r    <= pc_nx;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!hold_i) begin
         parcel_r <= parcel_nx;
      end
   end

   // word the queue expects next, given where the pc stands
   assign word_addr = {pc_r[rvc_pkg::xlen-1:2], 2'b00}
                      + ((state_r == rvc_pkg::st_half) ? 32'd4 : 32'd0);

   a_no_emit_on_hold: assert property (
      @(posedge clk_i) disable iff (!rst_i)
      hold_i |-> !queue_o.valid
   ) else $error("queue emitted while held");

   a_pc_halfword: assert property (
      @(posedge clk_i) disable iff (!rst_i)
      queue_o.valid |-> !queue_o.pc[0]
   ) else $error("queue pc not halfword aligned: %h", queue_o.pc);

   // fetch address and queue pc must stay in step
   a_word_in_step: assert property (
      @(posedge clk_i) disable iff (!rst_i)
      fetch_i.valid && active |-> fetch_i.addr == word_addr
   ) else $error("fetched word %h does not follow pc %h", fetch_i.addr, pc_r);

endmodule

/* hdl/rvc_expander.sv */
`timescale 1ns/1ps

module rvc_expander (
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic                hold_i,
   input  rvc_pkg::queue_out_t queue_i,
   output rvc_pkg::exp_out_t   out_o
);

   logic [15:0]              c;
   logic [4:0]               rd;
   logic [4:0]               rs2;
   logic [11:0]              imm6;
   logic [rvc_pkg::xlen-1:0] exp_instr;
   logic                     exp_illegal;
   logic [rvc_pkg::xlen-1:0] instr_r;
   logic [rvc_pkg::xlen-1:0] pc_r;
   logic                     illegal_r;
   logic                     valid_r;

   assign c    = queue_i.instr[15:0];
   assign rd   = c[11:7];
   assign rs2  = c[6:2];
   // sign extended 6-bit immediate of the CI format
   assign imm6 = {{6{c[12]}}, c[12], c[6:2]};

   always_comb begin
      exp_instr   = '0;
      exp_illegal = 1'b0;

      if (!queue_i.compressed) begin
         exp_instr = queue_i.instr;
      end
      else begin
         case (c[1:0])
            2'b01: begin
               case (c[15:13])
                  3'b000: begin
                     if (rd == 5'd0 && imm6 == 12'd0) begin
                        exp_instr = rvc_pkg::nop_instr;
                     end
                     else begin
                        exp_instr = {imm6, rd, 3'b000, rd, rvc_pkg::opc_op_imm};
                     end
                  end
                  3'b010: begin
                     // c.li
                     exp_instr = {imm6, 5'd0, 3'b000, rd, rvc_pkg::opc_op_imm};
                  end
                  3'b011: begin
                     // rd 2 is c.addi16sp, not in the subset
                     if (rd == 5'd0 || rd == 5'd2 || imm6 == 12'd0) begin
                        exp_illegal = 1'b1;
                     end
                     else begin
                        exp_instr = {{8{c[12]}}, imm6, rd, rvc_pkg::opc_lui};
                     end
                  end
                  3'b101: begin
                     // c.j, offset bits scattered over the CJ format
                     exp_instr = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                                  c[12], {8{c[12]}}, 5'd0, rvc_pkg::opc_jal};
                  end
                  default: begin
                     exp_illegal = 1'b1;
                  end
               endcase
            end

            2'b10: begin
               if (c[15:13] != 3'b100) begin
                  exp_illegal = 1'b1;
               end
               else if (!c[12]) begin
                  if (rs2 != 5'd0) begin
                     // c.mv
                     exp_instr = {7'd0, rs2, 5'd0, 3'b000, rd, rvc_pkg::opc_op};
                  end
                  else if (rd != 5'd0) begin
                     // c.jr
                     exp_instr = {12'd0, rd, 3'b000, 5'd0, rvc_pkg::opc_jalr};
                  end
                  else begin
                     exp_illegal = 1'b1;
                  end
               end
               else if (rs2 != 5'd0) begin
                  // c.add
                  exp_instr = {7'd0, rs2, rd, 3'b000, rd, rvc_pkg::opc_op};
               end
               else begin
                  // c.jalr and c.ebreak are outside the subset
                  exp_illegal = 1'b1;
               end
            end

            default: begin
               exp_illegal = 1'b1;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         valid_r <= 1'b0;
      end
      else if (!hold_i) begin
         valid_r <= queue_i.valid;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!hold_i) begin
         instr_r   <= exp_instr;
         pc_r      <= queue_i.pc;
         illegal_r <= exp_illegal;
      end
   end

   // result waits frozen under hold and shows once released
   always_comb begin
      out_o.instr   = instr_r;
      out_o.pc      = pc_r;
      out_o.illegal = illegal_r;
      out_o.valid   = valid_r && !hold_i;
   end

   a_full_never_illegal: assert property (
      @(posedge clk_i) disable iff (!rst_i)
      queue_i.valid && !queue_i.compressed && !hold_i |=> !out_o.illegal
   ) else $error("32-bit instruction flagged illegal at pc %h", out_o.pc);

endmodule

/* hdl/rvc_pkg.sv */
package rvc_pkg;

   localparam int unsigned xlen = 32;

   localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

   // low two bits of a 32-bit instruction
   localparam logic [1:0] op_full = 2'b11;

   // base opcodes used by the expander
   localparam logic [6:0] opc_op_imm = 7'b0010011;
   localparam logic [6:0] opc_op     = 7'b0110011;
   localparam logic [6:0] opc_lui    = 7'b0110111;
   localparam logic [6:0] opc_jal    = 7'b1101111;
   localparam logic [6:0] opc_jalr   = 7'b1100111;

   // addi x0, x0, 0
   localparam logic [xlen-1:0] nop_instr = {12'd0, 5'd0, 3'b000, 5'd0, opc_op_imm};

   // instruction queue states
   localparam logic [1:0] st_empty = 2'b00;
   localparam logic [1:0] st_half  = 2'b01;
   localparam logic [1:0] st_comp  = 2'b10;
   localparam logic [1:0] st_jump  = 2'b11;

   typedef union packed {
      logic [xlen-1:0]  word;
      logic [1:0][15:0] half;
   } fetch_word_u;

   typedef struct packed {
      fetch_word_u     data;
      logic [xlen-1:0] addr;
      logic            valid;
   } fetch_req_t;

   typedef struct packed {
      logic [xlen-1:0] instr;
      logic [xlen-1:0] pc;
      logic            compressed;
      logic            valid;
   } queue_out_t;

   typedef struct packed {
      logic [xlen-1:0] instr;
      logic [xlen-1:0] pc;
      logic            illegal;
      logic            valid;
   } exp_out_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# Build and run the fetch front end testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
   echo "verilator not found in PATH"
   exit 1
fi

verilator --binary --timing --assert -j 0 \
   --top-module tb_fetch_top -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/Vtb_fetch_top 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "sim passed"; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* verification/tb_fetch_top.sv */
`timescale 1ns/1ps

module tb_fetch_top;

   logic              clk_i = 1'b0;
   logic              rst_i;
   logic              hold_i;
   logic              redirect_i;
   logic [31:0]       redirect_pc_i;
   logic [31:0]       imem_data_i;
   logic [31:0]       imem_addr_o;
   rvc_pkg::exp_out_t out_o;

   // 512 bytes of halfwords
   logic [15:0] imem [0:255];
   logic [7:0]  rd_idx;

   logic [31:0] walk_pc;
   logic [31:0] exp_instr;
   logic        exp_illegal;
   logic [31:0] exp_len;
   int          checked;
   int          seed;

   fetch_top i_dut (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .hold_i        (hold_i),
      .redirect_i    (redirect_i),
      .redirect_pc_i (redirect_pc_i),
      .imem_data_i   (imem_data_i),
      .imem_addr_o   (imem_addr_o),
      .out_o         (out_o)
   );

   // memory answers in the same cycle
   assign rd_idx      = imem_addr_o[8:1];
   assign imem_data_i = {imem[rd_idx + 8'd1], imem[rd_idx]};

   initial begin
      forever #4 clk_i = ~clk_i;
   end

   // outside the program every word is a 32-bit instruction tied to its address
   function automatic logic [15:0] fill_half(input logic [7:0] idx);
      return idx[0] ? {8'hc3, idx} : {idx, 6'b010101, 2'b11};
   endfunction

   task automatic put16(input logic [31:0] addr, input logic [15:0] h);
      imem[addr[8:1]] = h;
   endtask

   task automatic put32(input logic [31:0] addr, input logic [31:0] w);
      logic [7:0] idx;
      idx = addr[8:1];
      imem[idx] = w[15:0];
      imem[idx + 8'd1] = w[31:16];
   endtask

   task automatic load_program();
      for (int i = 0; i < 256; i++) begin
         imem[i] = fill_half(8'(i));
      end
      put32(32'h00, 32'h0050_0093);  // addi x1, x0, 5
      put32(32'h04, 32'h0070_0113);  // addi x2, x0, 7
      put32(32'h08, 32'h0020_81b3);  // add x3, x1, x2
      put16(32'h0c, 16'h0085);       // c.addi x1, 1
      put16(32'h0e, 16'h410d);       // c.li x2, 3
      put16(32'h10, 16'h0001);       // c.nop
      put32(32'h12, 32'h1234_5237);  // lui x4 straddling 0x14
      put16(32'h16, 16'h818a);       // c.mv x3, x2
      put16(32'h18, 16'h9186);       // c.add x3, x1
      put16(32'h1a, 16'h4188);       // c.lw is outside the subset
      put16(32'h1c, 16'h10fd);       // c.addi x1, -1
      put32(32'h1e, 32'h0041_82b3);  // add x5, x3, x4 straddling 0x20
      put16(32'h22, 16'h6285);       // c.lui x5, 1
      put16(32'h24, 16'ha021);       // c.j +8
      put16(32'h26, 16'h8082);       // c.jr x1
      put32(32'h28, 32'habcd_e337);  // lui x6
      put32(32'h2c, 32'hfff0_0393);  // addi x7, x0, -1
   endtask

   function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [4:0] rd, input logic [6:0] op);
      return {imm, rs1, 3'b000, rd, op};
   endfunction

   function automatic logic [31:0] enc_r(input logic [4:0] rs2, input logic [4:0] rs1,
                                         input logic [4:0] rd);
      return {7'd0, rs2, rs1, 3'b000, rd, 7'b0110011};
   endfunction

   // expected 32-bit form of one compressed parcel
   function automatic void expand_ref(input logic [15:0] c, output logic [31:0] instr,
                                      output logic illegal);
      logic [4:0]  rd;
      logic [4:0]  rs2;
      logic [11:0] imm;
      logic [20:0] joff;
      rd      = c[11:7];
      rs2     = c[6:2];
      imm     = {{7{c[12]}}, c[6:2]};
      joff    = {{10{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
      instr   = 32'd0;
      illegal = 1'b0;
      if (c[1:0] == 2'b01 && c[15:13] == 3'b000) begin
         instr = enc_i(imm, rd, rd, 7'b0010011);
      end
      else if (c[1:0] == 2'b01 && c[15:13] == 3'b010) begin
         instr = enc_i(imm, 5'd0, rd, 7'b0010011);
      end
      else if (c[1:0] == 2'b01 && c[15:13] == 3'b011 && rd != 5'd0 && rd != 5'd2 &&
               imm != 12'd0) begin
         instr = {{14{c[12]}}, c[12], c[6:2], rd, 7'b0110111};
      end
      else if (c[1:0] == 2'b01 && c[15:13] == 3'b101) begin
         instr = {joff[20], joff[10:1], joff[11], joff[19:12], 5'd0, 7'b1101111};
      end
      else if (c[1:0] == 2'b10 && c[15:13] == 3'b100 && !c[12] && rs2 != 5'd0) begin
         instr = enc_r(rs2, 5'd0, rd);
      end
      else if (c[1:0] == 2'b10 && c[15:13] == 3'b100 && !c[12] && rd != 5'd0) begin
         instr = enc_i(12'd0, rd, 5'd0, 7'b1100111);
      end
      else if (c[1:0] == 2'b10 && c[15:13] == 3'b100 && c[12] && rs2 != 5'd0) begin
         instr = enc_r(rs2, rd, rd);
      end
      else begin
         illegal = 1'b1;
      end
   endfunction

   // next instruction of the reference walk at pc
   function automatic void predict(input logic [31:0] pc, output logic [31:0] instr,
                                   output logic illegal, output logic [31:0] len);
      logic [15:0] lo;
      logic [7:0]  idx;
      idx = pc[8:1];
      lo  = imem[idx];
      if (lo[1:0] == rvc_pkg::op_full) begin
         instr   = {imem[idx + 8'd1], lo};
         illegal = 1'b0;
         len     = 32'd4;
      end
      else begin
         expand_ref(lo, instr, illegal);
         len = 32'd2;
      end
   endfunction

   task automatic report_mismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] want);
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, want);
      $display("sim failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic report_timeout(input string what);
      $display("timeout in %s: instruction at pc %h never arrived", what, walk_pc);
      $display("sim failed");
      $fatal(1, "stopped on timeout");
   endtask

   // every emitted instruction against the reference walk
   always @(negedge clk_i) begin
      if (!rst_i) begin
         assert (!out_o.valid)
            else report_mismatch("valid in reset", {31'd0, out_o.valid}, 32'd0);
         assert (imem_addr_o == rvc_pkg::reset_pc)
            else report_mismatch("fetch address in reset", imem_addr_o, rvc_pkg::reset_pc);
      end
      else begin
         assert (!(hold_i && out_o.valid))
            else report_mismatch("valid while held", {31'd0, out_o.valid}, 32'd0);
         if (out_o.valid) begin
            predict(walk_pc, exp_instr, exp_illegal, exp_len);
            assert (out_o.pc == walk_pc)
               else report_mismatch("pc", out_o.pc, walk_pc);
            assert (out_o.instr == exp_instr)
               else report_mismatch("instr", out_o.instr, exp_instr);
            assert (out_o.illegal == exp_illegal)
               else report_mismatch("illegal", {31'd0, out_o.illegal}, {31'd0, exp_illegal});
            walk_pc = walk_pc + exp_len;
            checked = checked + 1;
         end
         // output of this cycle still predates the jump
         if (redirect_i) begin
            walk_pc = redirect_pc_i;
         end
      end
   end

   task automatic wait_outputs(input int n, input logic with_hold, input string what);
      int target;
      int cycles;
      int limit;
      target = checked + n;
      cycles = 0;
      limit  = n * 16 + 64;
      while (checked < target) begin
         @(posedge clk_i);
         #1;
         if (with_hold) begin
            hold_i = (($random(seed) & 3) == 0);
         end
         cycles = cycles + 1;
         if (cycles > limit) begin
            report_timeout(what);
         end
      end
      hold_i = 1'b0;
   endtask

   task automatic redirect_to(input logic [31:0] target);
      @(posedge clk_i);
      #1;
      redirect_i    = 1'b1;
      redirect_pc_i = target;
      @(posedge clk_i);
      #1;
      redirect_i = 1'b0;
   endtask

   initial begin
      rst_i         = 1'b0;
      hold_i        = 1'b0;
      redirect_i    = 1'b0;
      redirect_pc_i = 32'd0;
      seed          = 42203;
      checked       = 0;
      walk_pc       = rvc_pkg::reset_pc;
      load_program();

      repeat (4) @(posedge clk_i);
      #1;
      rst_i = 1'b1;

      // first word on the bus and nothing registered yet
      @(negedge clk_i);
      assert (!out_o.valid)
         else report_mismatch("valid in first cycle", {31'd0, out_o.valid}, 32'd0);
      assert (imem_addr_o == rvc_pkg::reset_pc)
         else report_mismatch("first fetch address", imem_addr_o, rvc_pkg::reset_pc);

      wait_outputs(17, 1'b0, "program run from reset");
      redirect_to(32'h0000_000e);
      wait_outputs(4, 1'b0, "redirect to upper compressed half");
      redirect_to(32'h0000_0012);
      wait_outputs(3, 1'b0, "redirect to straddling lui");
      redirect_to(32'h0000_001e);
      wait_outputs(5, 1'b0, "redirect to straddling add");
      redirect_to(32'h0000_0000);
      wait_outputs(22, 1'b1, "program run under random hold");
      redirect_to(32'h0000_001a);
      wait_outputs(10, 1'b1, "redirect to illegal parcel under hold");

      $display("sim passed");
      $finish;
   end

endmodule
